//--- can_bridge_params.svh
`ifndef CAN_BRIDGE_PARAMS_SVH
`define CAN_BRIDGE_PARAMS_SVH

`define CAN_ADDR_W          5         // Controller register address
`define CAN_DATA_W          16        // Controller register word
`define CAN_ID_W            11        // Standard identifier
`define CAN_MSG_DATA_W      64        // Eight payload bytes
`define CAN_BUF_W           5         // Transmit buffer select
`define CAN_NUM_REGS        32

`define CAN_INIT_LEN        6         // Configuration writes after reset
`define CAN_INIT_IDX_W      3
`define CAN_MSG_WRITES      8         // Register writes per message
`define CAN_TX_BUSY_CYCLES  5
`define CAN_BUSY_BIT        15        // Transmit request and busy flag

`define CAN_GEN_WORD        16'h009C
`define CAN_IRQ_WORD        16'h8070  // Clears pending interrupts
`define CAN_TRA_CTRL_WORD   16'h8008

`endif

//--- can_bridge_pkg.sv
`include "can_bridge_params.svh"

package can_bridge_pkg;

  typedef enum logic [1:0] {
    CMD_IDLE  = 2'd0,
    CMD_INIT  = 2'd1,
    CMD_READ  = 2'd2,
    CMD_WRITE = 2'd3
  } reg_cmd_t;

  typedef enum logic [`CAN_ADDR_W-1:0] {
    REG_TRA_D78  = 5'h07,
    REG_TRA_D56  = 5'h08,
    REG_TRA_D34  = 5'h09,
    REG_TRA_D12  = 5'h0A,
    REG_TRA_ID   = 5'h0C,
    REG_TRA_CTRL = 5'h0D,
    REG_GENERAL  = 5'h0E,
    REG_IRQ      = 5'h12
  } can_reg_addr_t;

  typedef enum logic [2:0] {
    S_INIT,
    S_IDLE,
    S_WRITE,
    S_POLL,
    S_ACK
  } seq_state_t;

  typedef struct packed {
    logic [`CAN_ID_W-1:0]       ident;
    logic [`CAN_MSG_DATA_W-1:0] data;     // Byte b7 on top, b0 at bottom
    logic [`CAN_BUF_W-1:0]      buf_sel;
  } tx_msg_t;

  typedef struct packed {
    logic [`CAN_ID_W-1:0]       ident;
    logic [`CAN_MSG_DATA_W-1:0] data;     // First bus byte on top
    logic [`CAN_BUF_W-1:0]      buf_sel;
  } tx_frame_t;

  typedef struct packed {
    reg_cmd_t               cmd;
    logic [`CAN_ADDR_W-1:0] addr;
  } reg_access_t;

  typedef struct packed {
    logic [`CAN_ADDR_W-1:0] addr;
    logic [`CAN_DATA_W-1:0] data;
  } init_entry_t;

endpackage

//--- can_init_table.sv
`include "can_bridge_params.svh"

module can_init_table (
  input  logic                        clock,
  input  logic                        arst_n,
  input  logic [`CAN_INIT_IDX_W-1:0]  init_index,
  output can_bridge_pkg::init_entry_t init_entry
);

  can_bridge_pkg::init_entry_t entry_d;

  always_comb begin
    entry_d = '0;                                                   // Past end of table
    case (init_index)
      3'd0: entry_d = '{addr: 5'h02, data: 16'h0003};               // Baud prescaler
      3'd1: entry_d = '{addr: 5'h03, data: 16'h0B07};               // Bit timing segments
      3'd2: entry_d = '{addr: 5'h04, data: 16'h0023};               // Sync jump width
      3'd3: entry_d = '{addr: can_bridge_pkg::REG_GENERAL, data: 16'h0080};
      3'd4: entry_d = '{addr: can_bridge_pkg::REG_IRQ, data: 16'h0000};
      // Busy bit left clear so configuration never starts a transmit
      3'd5: entry_d = '{addr: can_bridge_pkg::REG_TRA_CTRL, data: 16'h0008};
      default: entry_d = '0;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      init_entry <= '0;
    end else begin
      init_entry <= entry_d;
    end
  end

endmodule

//--- can_access_seq.sv
`include "can_bridge_params.svh"

module can_access_seq (
  input  logic                        clock,
  input  logic                        arst_n,
  input  logic                        msg_req,
  input  can_bridge_pkg::init_entry_t init_entry,
  input  logic [`CAN_DATA_W-1:0]      read_can,
  output logic [`CAN_INIT_IDX_W-1:0]  init_index,
  output can_bridge_pkg::reg_access_t access,
  output logic                        msg_ack,
  output logic                        ready
);

  localparam int WR_CNT_W = $clog2(`CAN_MSG_WRITES);
  localparam logic [`CAN_INIT_IDX_W-1:0] INIT_LAST = `CAN_INIT_IDX_W'(`CAN_INIT_LEN);
  localparam logic [WR_CNT_W-1:0] WR_LAST = WR_CNT_W'(`CAN_MSG_WRITES - 1);

  can_bridge_pkg::seq_state_t state;
  can_bridge_pkg::seq_state_t state_nxt;
  logic [`CAN_INIT_IDX_W-1:0] init_cnt;    // Entry requested from the table
  logic [WR_CNT_W-1:0]        wr_cnt;      // Step in the message sequence

  // Register order of one message
  function automatic can_bridge_pkg::can_reg_addr_t msg_addr(
    input logic [WR_CNT_W-1:0] step
  );
    case (step)
      3'd0: msg_addr = can_bridge_pkg::REG_TRA_ID;
      3'd1: msg_addr = can_bridge_pkg::REG_TRA_D12;
      3'd2: msg_addr = can_bridge_pkg::REG_TRA_D34;
      3'd3: msg_addr = can_bridge_pkg::REG_TRA_D56;
      3'd4: msg_addr = can_bridge_pkg::REG_TRA_D78;
      3'd5: msg_addr = can_bridge_pkg::REG_GENERAL;
      3'd6: msg_addr = can_bridge_pkg::REG_IRQ;
      default: msg_addr = can_bridge_pkg::REG_TRA_CTRL;
    endcase
  endfunction

  always_comb begin
    state_nxt = state;
    case (state)
      can_bridge_pkg::S_INIT: begin
        if (init_cnt == INIT_LAST) begin
          state_nxt = can_bridge_pkg::S_IDLE;
        end
      end
      can_bridge_pkg::S_IDLE: begin
        if (msg_req) begin
          state_nxt = can_bridge_pkg::S_WRITE;
        end
      end
      can_bridge_pkg::S_WRITE: begin
        if (wr_cnt == WR_LAST) begin
          state_nxt = can_bridge_pkg::S_POLL;
        end
      end
      can_bridge_pkg::S_POLL: begin
        if (!read_can[`CAN_BUSY_BIT]) begin
          state_nxt = can_bridge_pkg::S_ACK;
        end
      end
      can_bridge_pkg::S_ACK: begin
        if (!msg_req) begin
          state_nxt = can_bridge_pkg::S_IDLE;   // Four-phase release
        end
      end
      default: state_nxt = can_bridge_pkg::S_IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state    <= can_bridge_pkg::S_INIT;
      init_cnt <= '0;
      wr_cnt   <= '0;
    end else begin
      state <= state_nxt;
      if (state == can_bridge_pkg::S_INIT) begin
        init_cnt <= init_cnt + 1'b1;
      end
      if (state == can_bridge_pkg::S_WRITE) begin
        wr_cnt <= wr_cnt + 1'b1;                // Wraps to zero after last step
      end
    end
  end

  // Table output lags the index by one cycle
  always_comb begin
    access.cmd  = can_bridge_pkg::CMD_IDLE;
    access.addr = '0;
    case (state)
      can_bridge_pkg::S_INIT: begin
        if (init_cnt != '0) begin
          access.cmd  = can_bridge_pkg::CMD_INIT;
          access.addr = init_entry.addr;
        end
      end
      can_bridge_pkg::S_WRITE: begin
        access.cmd  = can_bridge_pkg::CMD_WRITE;
        access.addr = msg_addr(wr_cnt);
      end
      can_bridge_pkg::S_POLL: begin
        access.cmd  = can_bridge_pkg::CMD_READ;
        access.addr = can_bridge_pkg::REG_TRA_CTRL;
      end
      default: access.cmd = can_bridge_pkg::CMD_IDLE;
    endcase
  end

  assign init_index = init_cnt;
  assign msg_ack    = (state == can_bridge_pkg::S_ACK);
  assign ready      = (state != can_bridge_pkg::S_INIT);   // Configuration done

endmodule

//--- can_reg_mux.sv
`include "can_bridge_params.svh"

module can_reg_mux (
  input  can_bridge_pkg::reg_access_t access,
  input  logic [`CAN_DATA_W-1:0]      data_init,
  input  can_bridge_pkg::tx_msg_t     msg,
  output logic [`CAN_DATA_W-1:0]      write_can,
  output logic [`CAN_BUF_W-1:0]       can_tra_select
);

  localparam int ID_PAD_W = `CAN_DATA_W - `CAN_ID_W;

  logic [7:0][7:0] msg_byte;                    // Index 7 is byte b7

  assign msg_byte = msg.data;

  always_comb begin
    write_can      = '0;
    can_tra_select = '0;
    case (access.cmd)
      can_bridge_pkg::CMD_INIT: begin
        write_can = data_init;                  // Configuration pass-through
      end
      can_bridge_pkg::CMD_WRITE: begin
        can_tra_select = msg.buf_sel;
        case (access.addr)
          can_bridge_pkg::REG_TRA_ID: begin
            write_can = {msg.ident, {ID_PAD_W{1'b0}}};
          end
          can_bridge_pkg::REG_TRA_D12: begin
            write_can = {msg_byte[7], msg_byte[5]};
          end
          can_bridge_pkg::REG_TRA_D34: begin
            write_can = {msg_byte[6], msg_byte[4]};
          end
          can_bridge_pkg::REG_TRA_D56: begin
            write_can = {msg_byte[0], msg_byte[1]};
          end
          can_bridge_pkg::REG_TRA_D78: begin
            write_can = {msg_byte[2], msg_byte[3]};
          end
          can_bridge_pkg::REG_GENERAL: begin
            write_can = `CAN_GEN_WORD;
          end
          can_bridge_pkg::REG_IRQ: begin
            write_can = `CAN_IRQ_WORD;
          end
          can_bridge_pkg::REG_TRA_CTRL: begin
            write_can = `CAN_TRA_CTRL_WORD;     // Sets transmit request
          end
          default: begin
            write_can      = '0;
            can_tra_select = '0;
          end
        endcase
      end
      default: begin
        write_can      = '0;                    // Reads and idle drive nothing
        can_tra_select = '0;
      end
    endcase
  end

endmodule

//--- can_node_regs.sv
`include "can_bridge_params.svh"

module can_node_regs (
  input  logic                        clock,
  input  logic                        arst_n,
  input  can_bridge_pkg::reg_access_t access,
  input  logic [`CAN_DATA_W-1:0]      write_can,
  input  logic [`CAN_BUF_W-1:0]       can_tra_select,
  output logic [`CAN_DATA_W-1:0]      read_can,
  output can_bridge_pkg::tx_frame_t   frame,
  output logic                        frame_valid
);

  localparam int BUSY_W = $clog2(`CAN_TX_BUSY_CYCLES + 1);

  logic [`CAN_DATA_W-1:0] regs [`CAN_NUM_REGS];
  logic [BUSY_W-1:0]      busy_cnt;
  logic                   wr_en;
  logic                   tx_start;
  logic                   busy;

  assign wr_en = (access.cmd == can_bridge_pkg::CMD_INIT) ||
                 (access.cmd == can_bridge_pkg::CMD_WRITE);
  assign tx_start = wr_en && (access.addr == can_bridge_pkg::REG_TRA_CTRL) &&
                    write_can[`CAN_BUSY_BIT];
  assign busy = (busy_cnt != '0);

  always_ff @(posedge clock) begin
    if (wr_en) begin
      regs[access.addr] <= write_can;
    end
  end

  // Bus bytes leave in register order D12, D34, D56, D78
  always_ff @(posedge clock) begin
    if (tx_start) begin
      frame.ident   <= regs[can_bridge_pkg::REG_TRA_ID][`CAN_DATA_W-1 -: `CAN_ID_W];
      frame.data    <= {regs[can_bridge_pkg::REG_TRA_D12],
                        regs[can_bridge_pkg::REG_TRA_D34],
                        regs[can_bridge_pkg::REG_TRA_D56],
                        regs[can_bridge_pkg::REG_TRA_D78]};
      frame.buf_sel <= can_tra_select;          // Latched buffer select
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      frame_valid <= 1'b0;
      busy_cnt    <= '0;
    end else begin
      frame_valid <= tx_start;
      if (tx_start) begin
        busy_cnt <= BUSY_W'(`CAN_TX_BUSY_CYCLES);
      end else if (busy) begin
        busy_cnt <= busy_cnt - 1'b1;
      end
    end
  end

  always_comb begin
    read_can = '0;
    if (access.cmd == can_bridge_pkg::CMD_READ) begin
      read_can = regs[access.addr];
      if (access.addr == can_bridge_pkg::REG_TRA_CTRL) begin
        read_can[`CAN_BUSY_BIT] = busy;         // Live transmit status
      end
    end
  end

endmodule

//--- can_tx_bridge.sv
`include "can_bridge_params.svh"

module can_tx_bridge (
  input  logic                      clock,
  input  logic                      arst_n,
  input  logic                      msg_req,
  input  can_bridge_pkg::tx_msg_t   msg,
  output logic                      msg_ack,
  output logic                      ready,
  output can_bridge_pkg::tx_frame_t frame,
  output logic                      frame_valid
);

  can_bridge_pkg::init_entry_t init_entry;
  can_bridge_pkg::reg_access_t access;
  logic [`CAN_INIT_IDX_W-1:0]  init_index;
  logic [`CAN_DATA_W-1:0]      write_can;
  logic [`CAN_DATA_W-1:0]      read_can;
  logic [`CAN_BUF_W-1:0]       can_tra_select;

  can_init_table u_init_table (
    .clock      (clock),
    .arst_n     (arst_n),
    .init_index (init_index),
    .init_entry (init_entry)
  );

  can_access_seq u_access_seq (
    .clock      (clock),
    .arst_n     (arst_n),
    .msg_req    (msg_req),
    .init_entry (init_entry),
    .read_can   (read_can),
    .init_index (init_index),
    .access     (access),
    .msg_ack    (msg_ack),
    .ready      (ready)
  );

  can_reg_mux u_reg_mux (
    .access         (access),
    .data_init      (init_entry.data),          // Init word straight from the table
    .msg            (msg),
    .write_can      (write_can),
    .can_tra_select (can_tra_select)
  );

  can_node_regs u_node_regs (
    .clock          (clock),
    .arst_n         (arst_n),
    .access         (access),
    .write_can      (write_can),
    .can_tra_select (can_tra_select),
    .read_can       (read_can),
    .frame          (frame),
    .frame_valid    (frame_valid)
  );

endmodule

//--- can_tx_bridge_properties.sv
`include "can_bridge_params.svh"

module can_tx_bridge_properties (
  input logic                      clock,
  input logic                      arst_n,
  input logic                      msg_req,
  input can_bridge_pkg::tx_msg_t   msg,
  input logic                      msg_ack,
  input logic                      ready,
  input can_bridge_pkg::tx_frame_t frame,
  input logic                      frame_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  can_bridge_pkg::tx_msg_t held_msg;   // Last accepted message
  logic in_flight;                     // Request between accept and release
  logic accept;
  int   init_cycles;
  int   frame_cnt;                     // Frames seen for the current request
  int   since_frame;                   // Cycles since the last frame_valid
  int   err_init = 0;
  int   err_quiet = 0;
  int   err_ident = 0;
  int   err_data = 0;
  int   err_once = 0;
  int   err_ack_order = 0;
  int   err_ack_hold = 0;
  int   err_ack_drop = 0;
  int   fail_count;

  assign fail_count = err_init + err_quiet + err_ident + err_data + err_once +
                      err_ack_order + err_ack_hold + err_ack_drop;
  assign accept = ready && msg_req && !msg_ack && !in_flight;

  // Bus byte order on the wire: b7 b5 b6 b4 b0 b1 b2 b3
  function automatic logic [63:0] bus_order(input logic [63:0] d);
    logic [7:0] b [8];
    for (int i = 0; i < 8; i++) begin
      b[i] = d[8*i +: 8];
    end
    return {b[7], b[5], b[6], b[4], b[0], b[1], b[2], b[3]};
  endfunction

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      held_msg    <= '0;
      in_flight   <= 1'b0;
      init_cycles <= 0;
      frame_cnt   <= 0;
      since_frame <= 0;
    end else begin
      if (!ready) begin
        init_cycles <= init_cycles + 1;
      end
      if (accept) begin
        held_msg  <= msg;
        in_flight <= 1'b1;
        frame_cnt <= 0;
      end else if (in_flight && msg_ack && !msg_req) begin
        in_flight <= 1'b0;                  // Host released the request
      end
      if (frame_valid) begin
        frame_cnt   <= frame_cnt + 1;
        since_frame <= 1;
      end else if (since_frame < 255) begin
        since_frame <= since_frame + 1;
      end
    end
  end

  a_init_time: assert property (@(posedge clock) disable iff (!arst_n)
    $rose(ready) |-> init_cycles == `CAN_INIT_LEN + 1)
    else begin
      err_init++;
      $error("CHECK FAILED at %0t: ready rose after %0d cycles", $time, init_cycles);
    end

  a_quiet_init: assert property (@(posedge clock) disable iff (!arst_n)
    !ready |-> !frame_valid && !msg_ack)
    else begin
      err_quiet++;
      $error("CHECK FAILED at %0t: frame_valid or msg_ack before ready", $time);
    end

  a_frame_ident: assert property (@(posedge clock) disable iff (!arst_n)
    frame_valid |-> frame.ident == held_msg.ident && frame.buf_sel == held_msg.buf_sel)
    else begin
      err_ident++;
      $error("CHECK FAILED at %0t: frame ident or buffer select mismatch", $time);
    end

  a_frame_data: assert property (@(posedge clock) disable iff (!arst_n)
    frame_valid |-> frame.data == bus_order(held_msg.data))
    else begin
      err_data++;
      $error("CHECK FAILED at %0t: frame data %h is in wrong byte order", $time, frame.data);
    end

  a_one_frame: assert property (@(posedge clock) disable iff (!arst_n)
    frame_valid |-> in_flight && frame_cnt == 0)
    else begin
      err_once++;
      $error("CHECK FAILED at %0t: frame without request or repeated frame", $time);
    end

  a_ack_after_frame: assert property (@(posedge clock) disable iff (!arst_n)
    $rose(msg_ack) |-> in_flight && frame_cnt == 1 && since_frame >= `CAN_TX_BUSY_CYCLES)
    else begin
      err_ack_order++;
      $error("CHECK FAILED at %0t: msg_ack %0d cycles after frame", $time, since_frame);
    end

  a_ack_hold: assert property (@(posedge clock) disable iff (!arst_n)
    msg_ack && msg_req |=> msg_ack)
    else begin
      err_ack_hold++;
      $error("CHECK FAILED at %0t: msg_ack fell while msg_req high", $time);
    end

  a_ack_drop: assert property (@(posedge clock) disable iff (!arst_n)
    msg_ack && !msg_req |=> !msg_ack)
    else begin
      err_ack_drop++;
      $error("CHECK FAILED at %0t: msg_ack held after msg_req fell", $time);
    end

endmodule

//--- tb_can_tx_bridge.sv
module tb_can_tx_bridge;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_MSGS      = 20;
  localparam int READY_TIMEOUT = 50;     // Cycles
  localparam int ACK_TIMEOUT   = 200;
  localparam int DROP_TIMEOUT  = 10;

  logic                      clock;
  logic                      arst_n;
  logic                      msg_req;
  can_bridge_pkg::tx_msg_t   msg;
  logic                      msg_ack;
  logic                      ready;
  can_bridge_pkg::tx_frame_t frame;
  logic                      frame_valid;

  logic [31:0] rng_state;
  int          timeout_count;
  int          sent_count;

  can_tx_bridge UUT (
    .clock       (clock),
    .arst_n      (arst_n),
    .msg_req     (msg_req),
    .msg         (msg),
    .msg_ack     (msg_ack),
    .ready       (ready),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

  bind can_tx_bridge can_tx_bridge_properties u_props (
    .clock       (clock),
    .arst_n      (arst_n),
    .msg_req     (msg_req),
    .msg         (msg),
    .msg_ack     (msg_ack),
    .ready       (ready),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;          // 100 ns period
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw_random(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (!(ready && !msg_ack) && cycles < READY_TIMEOUT) begin
      @(posedge clock);
      cycles++;
    end
    if (!(ready && !msg_ack)) begin
      $display("Timeout: bridge was not ready for a new message at %0t", $time);
      timeout_count++;
    end
  endtask

  // Four-phase request with the host holding req a few extra cycles
  task automatic send_message(input can_bridge_pkg::tx_msg_t m, input int hold_extra);
    int cycles;
    msg     <= m;
    msg_req <= 1'b1;
    cycles = 0;
    do begin
      @(posedge clock);
      cycles++;
    end while (!msg_ack && cycles < ACK_TIMEOUT);
    if (!msg_ack) begin
      $display("Timeout: no msg_ack for message %0d at %0t", sent_count, $time);
      timeout_count++;
      msg_req <= 1'b0;
    end else begin
      repeat (hold_extra) @(posedge clock);
      msg_req <= 1'b0;
      cycles = 0;
      do begin
        @(posedge clock);
        cycles++;
      end while (msg_ack && cycles < DROP_TIMEOUT);
      if (msg_ack) begin
        $display("Timeout: msg_ack stayed high after release at %0t", $time);
        timeout_count++;
      end
    end
  endtask

  initial begin : stimulus
    can_bridge_pkg::tx_msg_t m;
    logic [31:0] r;
    int fails;
    arst_n        = 1'b0;
    msg_req       = 1'b0;
    msg           = '0;
    rng_state     = 32'd30;
    timeout_count = 0;
    sent_count    = 0;
    repeat (3) @(posedge clock);
    arst_n <= 1'b1;
    wait_ready();
    for (int i = 0; i < NUM_MSGS && timeout_count == 0; i++) begin
      draw_random(r);
      m.ident   = r[10:0];
      m.buf_sel = r[15:11];
      draw_random(r);
      m.data[63:32] = r;
      draw_random(r);
      m.data[31:0] = r;
      draw_random(r);                    // Idle gap and hold length
      repeat (r[3:2]) @(posedge clock);
      wait_ready();
      if (timeout_count == 0) begin
        send_message(m, int'(r[1:0]));
        sent_count++;
      end
    end
    repeat (4) @(posedge clock);         // Last release checks
    fails = UUT.u_props.fail_count;
    $display("Summary: %0d assertion failures, %0d timeouts, %0d of %0d messages sent",
             fails, timeout_count, sent_count, NUM_MSGS);
    if (fails == 0 && timeout_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+.
can_bridge_pkg.sv
can_init_table.sv
can_access_seq.sv
can_reg_mux.sv
can_node_regs.sv
can_tx_bridge.sv
can_tx_bridge_properties.sv
tb_can_tx_bridge.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run the testbench, then scan the log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_can_tx_bridge -f list.f -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim +verilator+error+limit+1000 > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0
